/* hdl/spi_link_settings.svh */
`ifndef SPI_LINK_SETTINGS_SVH
`define SPI_LINK_SETTINGS_SVH

// Entries in each of the four queues
`define SPI_FIFO_DEPTH 8

// Clock cycles per SCLK half-period
`define SPI_CLOCK_DIV 4

// First byte the target sends in every frame
`define SPI_HEADER 8'h27

`define SPI_TIMEOUT_PER_CASE 400

`endif

/* hdl/spi_types_pkg.sv */
package spi_types_pkg;

  typedef logic [7:0] byte_t;

  // Byte plus end-of-frame marker, last sits in bit 8
  typedef struct packed {
    logic  last;
    byte_t data;
  } tx_item_t;

  // Bit 0 is master_rx_ready
  typedef struct packed {
    logic [1:0] reserved;
    logic       underrun;
    logic       overflow;
    logic       busy;
    logic       master_tx_empty;
    logic       target_rx_ready;
    logic       master_rx_ready;
  } status_t;

endpackage

/* hdl/apb_regs_pkg.sv */
package apb_regs_pkg;

  typedef logic [7:0] apb_addr_t;

  // Register map
  typedef enum apb_addr_t {
    REG_MASTER_TX = 8'h00,
    REG_MASTER_RX = 8'h04,
    REG_TARGET_TX = 8'h08,
    REG_TARGET_RX = 8'h0C,
    REG_STATUS    = 8'h10
  } reg_addr_e;

endpackage

/* hdl/byte_stream_if.sv */
`timescale 1ns/1ns

interface byte_stream_if import spi_types_pkg::*; ();

  logic  valid;
  logic  ready;
  logic  last;
  byte_t data;

  // Source holds valid and data steady until ready
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* hdl/stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 4
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  push,
  input  item_t push_item,
  output logic  full,
  input  logic  pop,
  output item_t head,
  output logic  empty
);

  localparam int AW = $clog2(DEPTH);

  item_t          mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;

  assign full  = count == (AW + 1)'(DEPTH);
  assign empty = count == '0;
  assign head  = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  // Callers must respect full and empty
  assert property (@(posedge clock) disable iff (reset) !(push && full));
  assert property (@(posedge clock) disable iff (reset) !(pop && empty));

endmodule

/* hdl/spi_master.sv */
`timescale 1ns/1ns
`include "spi_link_settings.svh"

module spi_master import spi_types_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  byte_stream_if.sink   tx,
  byte_stream_if.source rx,
  output logic          sclk,
  output logic          ssel,
  output logic          mosi,
  input  logic          miso,
  output logic          busy
);

  localparam int DIV = `SPI_CLOCK_DIV;
  localparam int DW  = $clog2(DIV);

  typedef enum logic [2:0] {IDLE, SHIFT, WAIT, TRAIL, TAIL} state_e;

  state_e        state;
  logic [DW-1:0] div_cnt;
  logic [3:0]    phase;
  logic          tick;
  logic          byte_end;
  logic          take;
  logic          last_q;
  logic          rx_valid;
  logic          rx_last;
  byte_t         tx_shift;
  byte_t         rx_shift;
  byte_t         rx_data;

  assign tick     = div_cnt == DW'(DIV - 1);
  assign byte_end = state == SHIFT && tick && phase == 4'd15;
  // Next byte only starts once the previous one has a place in master RX
  assign tx.ready = rx.ready && !rx_valid &&
                    (state == IDLE || state == WAIT || (byte_end && !last_q));
  assign take     = tx.valid && tx.ready;
  assign mosi     = tx_shift[7];
  assign busy     = state != IDLE;
  assign rx.valid = rx_valid;
  assign rx.last  = rx_last;
  assign rx.data  = rx_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      div_cnt  <= '0;
      phase    <= '0;
      sclk     <= 1'b0;
      ssel     <= 1'b1;
      last_q   <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      div_cnt <= (state inside {SHIFT, TRAIL, TAIL} && !tick) ? div_cnt + 1'b1 : '0;
      if (rx_valid && rx.ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        IDLE, WAIT: begin
          if (take) begin
            ssel   <= 1'b0;
            last_q <= tx.last;
            state  <= SHIFT;
          end
        end
        SHIFT: begin
          if (tick) begin
            // Even phases rise, odd phases fall
            sclk  <= ~phase[0];
            phase <= phase + 1'b1;
          end
          if (byte_end) begin
            rx_valid <= 1'b1;
            if (last_q) begin
              state <= TRAIL;
            end else if (take) begin
              last_q <= tx.last;
            end else begin
              state <= WAIT;
            end
          end
        end
        TRAIL: begin
          if (tick) begin
            ssel  <= 1'b1;
            state <= TAIL;
          end
        end
        default: begin
          // Extra half-period so the target can flush its last byte
          if (tick) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      tx_shift <= tx.data;
    end else if (state == SHIFT && tick && phase[0]) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    if (state == SHIFT && tick && !phase[0]) begin
      rx_shift <= {rx_shift[6:0], miso};
    end
    if (byte_end) begin
      rx_data <= rx_shift;
      rx_last <= last_q;
    end
  end

  assert property (@(posedge clock) disable iff (reset) (phase != 4'd0) |=> $stable(ssel));

endmodule

/* hdl/spi_target.sv */
`timescale 1ns/1ns
`include "spi_link_settings.svh"

module spi_target import spi_types_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          sclk,
  input  logic          ssel,
  input  logic          mosi,
  output logic          miso,
  byte_stream_if.sink   tx,
  byte_stream_if.source rx,
  output logic          overflow_pulse,
  output logic          underrun_pulse
);

  logic       sclk_q;
  logic       sclk_d;
  logic       ssel_q;
  logic       ssel_d;
  logic       rise;
  logic       fall;
  logic       frame_start;
  logic       frame_end;
  logic       commit;
  logic       flush;
  logic       pending;
  logic       held;
  logic [2:0] bit_cnt;
  logic       rx_valid;
  logic       rx_last;
  byte_t      rx_data;
  byte_t      rx_shift;
  byte_t      held_byte;
  byte_t      tx_shift;

  assign rise        = sclk_q & ~sclk_d & ~ssel_q;
  assign fall        = ~sclk_q & sclk_d & ~ssel_q;
  assign frame_start = ~ssel_q & ssel_d;
  assign frame_end   = ssel_q & ~ssel_d;
  // Reply byte is taken on the first rising edge of the next byte
  assign commit      = rise & pending;
  // Held byte goes out on the next bit or at the end of the frame
  assign flush       = held & ((rise & bit_cnt == 3'd0) | frame_end);

  // While waiting on the next byte, MISO shows the reply queue head
  assign miso = pending ? (tx.valid & tx.data[7]) : tx_shift[7];

  assign tx.ready       = commit;
  assign underrun_pulse = commit & ~tx.valid;
  assign rx.valid       = rx_valid;
  assign rx.last        = rx_last;
  assign rx.data        = rx_data;
  assign overflow_pulse = rx_valid & ~rx.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      sclk_q   <= 1'b0;
      sclk_d   <= 1'b0;
      ssel_q   <= 1'b1;
      ssel_d   <= 1'b1;
      bit_cnt  <= '0;
      pending  <= 1'b0;
      held     <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      sclk_q   <= sclk;
      sclk_d   <= sclk_q;
      ssel_q   <= ssel;
      ssel_d   <= ssel_q;
      rx_valid <= flush;
      if (frame_start || frame_end) begin
        bit_cnt <= '0;
        pending <= 1'b0;
        held    <= 1'b0;
      end else begin
        if (rise) begin
          bit_cnt <= bit_cnt + 1'b1;
          held    <= bit_cnt == 3'd7;
        end
        if (commit) begin
          pending <= 1'b0;
        end else if (fall && bit_cnt == 3'd0) begin
          pending <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (frame_start) begin
      tx_shift <= `SPI_HEADER;
    end else if (commit) begin
      tx_shift <= tx.valid ? tx.data : '0;
    end else if (fall && bit_cnt != 3'd0) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    if (rise) begin
      rx_shift <= {rx_shift[6:0], mosi};
    end
    if (rise && bit_cnt == 3'd7) begin
      held_byte <= {rx_shift[6:0], mosi};
    end
    if (flush) begin
      rx_data <= held_byte;
      rx_last <= frame_end;
    end
  end

endmodule

/* hdl/apb_spi_regs.sv */
`timescale 1ns/1ns
`include "spi_link_settings.svh"

module apb_spi_regs import spi_types_pkg::*, apb_regs_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  apb_addr_t     paddr,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  byte_stream_if.source master_tx,
  byte_stream_if.sink   master_rx,
  byte_stream_if.source target_tx,
  byte_stream_if.sink   target_rx,
  input  logic          busy,
  input  logic          overflow_pulse,
  input  logic          underrun_pulse
);

  logic     access;
  logic     err;
  logic     mtx_push, mtx_full, mtx_empty;
  logic     mrx_pop, mrx_full, mrx_empty;
  logic     ttx_push, ttx_full, ttx_empty;
  logic     trx_pop, trx_full, trx_empty;
  logic     status_wr;
  logic     overflow;
  logic     underrun;
  tx_item_t mtx_head;
  tx_item_t trx_head;
  byte_t    mrx_head;
  byte_t    ttx_head;
  status_t  status;
  status_t  clear_bits;

  assign access     = psel & penable;
  assign pready     = 1'b1;
  assign pslverr    = access & err;
  assign clear_bits = status_t'(pwdata[7:0]);
  assign status_wr  = access && pwrite && paddr == REG_STATUS;

  assign status = '{reserved: 2'b00, underrun: underrun, overflow: overflow, busy: busy,
                    master_tx_empty: mtx_empty, target_rx_ready: !trx_empty,
                    master_rx_ready: !mrx_empty};

  // Decode, an erroring access leaves every queue alone
  always_comb begin
    err      = 1'b0;
    mtx_push = 1'b0;
    mrx_pop  = 1'b0;
    ttx_push = 1'b0;
    trx_pop  = 1'b0;
    prdata   = '0;
    case (paddr)
      REG_MASTER_TX: begin
        err      = !pwrite || mtx_full;
        mtx_push = access && !err;
      end
      REG_MASTER_RX: begin
        err     = pwrite || mrx_empty;
        mrx_pop = access && !err;
        prdata  = 32'(mrx_head);
      end
      REG_TARGET_TX: begin
        err      = !pwrite || ttx_full;
        ttx_push = access && !err;
      end
      REG_TARGET_RX: begin
        err     = pwrite || trx_empty;
        trx_pop = access && !err;
        prdata  = 32'(trx_head);
      end
      REG_STATUS: prdata = 32'(status);
      default: err = 1'b1;
    endcase
  end

  // Sticky flags, a new event wins over a clear
  always_ff @(posedge clock) begin
    if (reset) begin
      overflow <= 1'b0;
      underrun <= 1'b0;
    end else begin
      overflow <= (overflow & ~(status_wr & clear_bits.overflow)) | overflow_pulse;
      underrun <= (underrun & ~(status_wr & clear_bits.underrun)) | underrun_pulse;
    end
  end

  assign master_tx.valid = !mtx_empty;
  assign master_tx.last  = mtx_head.last;
  assign master_tx.data  = mtx_head.data;
  assign master_rx.ready = !mrx_full;
  assign target_tx.valid = !ttx_empty;
  assign target_tx.last  = 1'b0;
  assign target_tx.data  = ttx_head;
  assign target_rx.ready = !trx_full;

  stream_fifo #(.item_t(tx_item_t), .DEPTH(`SPI_FIFO_DEPTH)) master_tx_fifo (
    .clock(clock), .reset(reset),
    .push(mtx_push), .push_item(tx_item_t'(pwdata[8:0])), .full(mtx_full),
    .pop(master_tx.valid && master_tx.ready), .head(mtx_head), .empty(mtx_empty)
  );

  stream_fifo #(.item_t(byte_t), .DEPTH(`SPI_FIFO_DEPTH)) master_rx_fifo (
    .clock(clock), .reset(reset),
    .push(master_rx.valid && master_rx.ready), .push_item(master_rx.data), .full(mrx_full),
    .pop(mrx_pop), .head(mrx_head), .empty(mrx_empty)
  );

  stream_fifo #(.item_t(byte_t), .DEPTH(`SPI_FIFO_DEPTH)) target_tx_fifo (
    .clock(clock), .reset(reset),
    .push(ttx_push), .push_item(pwdata[7:0]), .full(ttx_full),
    .pop(target_tx.valid && target_tx.ready), .head(ttx_head), .empty(ttx_empty)
  );

  stream_fifo #(.item_t(tx_item_t), .DEPTH(`SPI_FIFO_DEPTH)) target_rx_fifo (
    .clock(clock), .reset(reset),
    .push(target_rx.valid && target_rx.ready),
    .push_item('{last: target_rx.last, data: target_rx.data}), .full(trx_full),
    .pop(trx_pop), .head(trx_head), .empty(trx_empty)
  );

endmodule

/* hdl/spi_link.sv */
`timescale 1ns/1ns

module spi_link import apb_regs_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  apb_addr_t   paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic sclk;
  logic ssel;
  logic mosi;
  logic miso;
  logic busy;
  logic overflow_pulse;
  logic underrun_pulse;

  byte_stream_if master_tx_stream ();
  byte_stream_if master_rx_stream ();
  byte_stream_if target_tx_stream ();
  byte_stream_if target_rx_stream ();

  apb_spi_regs regs (
    .clock(clock), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .master_tx(master_tx_stream.source), .master_rx(master_rx_stream.sink),
    .target_tx(target_tx_stream.source), .target_rx(target_rx_stream.sink),
    .busy(busy), .overflow_pulse(overflow_pulse), .underrun_pulse(underrun_pulse)
  );

  // Master and target share the four SPI wires
  spi_master master (
    .clock(clock), .reset(reset),
    .tx(master_tx_stream.sink), .rx(master_rx_stream.source),
    .sclk(sclk), .ssel(ssel), .mosi(mosi), .miso(miso), .busy(busy)
  );

  spi_target target (
    .clock(clock), .reset(reset),
    .sclk(sclk), .ssel(ssel), .mosi(mosi), .miso(miso),
    .tx(target_tx_stream.sink), .rx(target_rx_stream.source),
    .overflow_pulse(overflow_pulse), .underrun_pulse(underrun_pulse)
  );

endmodule

/* bench/spi_link_tb.sv */
`timescale 1ns/1ns
`include "spi_link_settings.svh"

module spi_link_tb import spi_types_pkg::*, apb_regs_pkg::*; ();

  logic        clock;
  logic        reset;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // One entry per operation line of the case file
  logic [7:0]  case_op[$];
  apb_addr_t   case_addr[$];
  logic [31:0] case_value[$];
  logic        case_err[$];
  int          case_line[$];

  int cycles = 0;
  int cycle_limit = 0;

  spi_link uut (
    .clock(clock), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles, the DUT never went idle", cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_item(input string name, input tx_item_t expected, input tx_item_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input status_t expected, input status_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          line_no;
    int          code;
    string       text;
    logic [7:0]  op;
    apb_addr_t   addr;
    logic [31:0] value;
    logic        err;
    fd = $fopen("bench/spi_link_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/spi_link_cases.txt from the project root");
      abort_run();
    end
    line_no = 0;
    while (!$feof(fd)) begin
      text = "";
      code = $fgets(text, fd);
      line_no++;
      if (code == 0 || text.len() < 2 || text.substr(0, 0) == "#") begin
        continue;
      end
      code = $sscanf(text, "%c %h %h %h", op, addr, value, err);
      if (code != 4) begin
        $display("Case file line %0d cannot be parsed", line_no);
        abort_run();
      end
      case_op.push_back(op);
      case_addr.push_back(addr);
      case_value.push_back(value);
      case_err.push_back(err);
      case_line.push_back(line_no);
    end
    $fclose(fd);
  endtask

  // Setup phase, access phase, then a random idle gap
  task automatic apb_access(input logic write, input apb_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    // No wait states, the transfer ends in this access phase
    check_err("pready", 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    repeat ($urandom_range(3, 0)) @(posedge clock);
  endtask

  task automatic poll_idle(input int idx);
    logic [31:0] rdata;
    logic        err;
    status_t     status;
    do begin
      apb_access(1'b0, REG_STATUS, '0, rdata, err);
      check_err($sformatf("pslverr, line %0d", case_line[idx]), 1'b0, err);
      status = status_t'(rdata[7:0]);
    end while (status.busy);
  endtask

  task automatic check_read(input int idx, input logic [31:0] rdata);
    string name;
    int    field_bits;
    name = $sformatf("prdata, line %0d", case_line[idx]);
    field_bits = 8;
    case (case_addr[idx])
      REG_MASTER_RX: check_byte(name, byte_t'(case_value[idx][7:0]), byte_t'(rdata[7:0]));
      REG_TARGET_RX: begin
        field_bits = 9;
        check_item(name, tx_item_t'(case_value[idx][8:0]), tx_item_t'(rdata[8:0]));
      end
      REG_STATUS: check_status(name, status_t'(case_value[idx][7:0]), status_t'(rdata[7:0]));
      default: begin
        $display("Case file line %0d reads a register with no data", case_line[idx]);
        abort_run();
      end
    endcase
    // Bits above the register field read as zero
    check_word($sformatf("prdata unused bits, line %0d", case_line[idx]), '0,
               rdata >> field_bits);
  endtask

  task automatic run_case(input int idx);
    logic [31:0] rdata;
    logic        err;
    case (case_op[idx])
      "W": begin
        apb_access(1'b1, case_addr[idx], case_value[idx], rdata, err);
        check_err($sformatf("pslverr, line %0d", case_line[idx]), case_err[idx], err);
      end
      "R": begin
        apb_access(1'b0, case_addr[idx], '0, rdata, err);
        check_err($sformatf("pslverr, line %0d", case_line[idx]), case_err[idx], err);
        // Data of a failed read is meaningless
        if (!case_err[idx]) begin
          check_read(idx, rdata);
        end
      end
      "P": poll_idle(idx);
      default: begin
        $display("Case file line %0d has an unknown operation", case_line[idx]);
        abort_run();
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'h95f2));
    clock   = 1'b0;
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    load_cases();
    cycle_limit = case_op.size() * `SPI_TIMEOUT_PER_CASE;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < case_op.size(); i++) begin
      run_case(i);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* spi_link.f */
+incdir+hdl
hdl/spi_types_pkg.sv
hdl/apb_regs_pkg.sv
hdl/byte_stream_if.sv
hdl/stream_fifo.sv
hdl/spi_master.sv
hdl/spi_target.sv
hdl/apb_spi_regs.sv
hdl/spi_link.sv
bench/spi_link_tb.sv

/* Makefile */
TOP = spi_link_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f spi_link.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

/* bench/spi_link_cases.txt */
# op addr value err: W writes value, R expects value, P polls STATUS until idle
# addr and value in hex, err is the expected pslverr
R 04 000 1
R 10 004 0
# Master to target, replies are the header then zeros
W 00 0a5 0
W 00 03c 0
W 00 1c3 0
P 10 000 0
R 0c 0a5 0
R 0c 03c 0
R 0c 1c3 0
R 04 027 0
R 04 000 0
R 04 000 0
R 10 024 0
W 10 020 0
R 10 004 0
# Target reply
W 08 05a 0
W 08 0e1 0
W 00 011 0
W 00 022 0
W 00 133 0
P 10 000 0
R 04 027 0
R 04 05a 0
R 04 0e1 0
R 0c 011 0
R 0c 022 0
R 0c 133 0
R 10 004 0
# Underrun
W 00 044 0
W 00 155 0
P 10 000 0
R 04 027 0
R 04 000 0
R 0c 044 0
R 0c 155 0
R 10 024 0
W 10 020 0
R 10 004 0
# Overflow over two frames, target RX keeps the first eight bytes
W 00 061 0
W 00 062 0
W 00 063 0
W 00 064 0
W 00 165 0
P 10 000 0
R 04 027 0
R 04 000 0
W 00 071 0
W 00 072 0
W 00 073 0
W 00 074 0
W 00 175 0
P 10 000 0
R 10 037 0
R 0c 061 0
R 0c 062 0
R 0c 063 0
R 0c 064 0
R 0c 165 0
R 0c 071 0
R 0c 072 0
R 0c 073 0
R 0c 000 1
R 10 035 0
# Unmapped read, then fill master TX while master RX is full
R 14 000 1
R 10 035 0
W 00 081 0
W 00 082 0
W 00 083 0
W 00 084 0
W 00 085 0
W 00 086 0
W 00 087 0
W 00 088 0
R 10 031 0
W 00 089 1
R 10 031 0
